//--- include/sdv_config.svh
`ifndef SDV_CONFIG_SVH
`define SDV_CONFIG_SVH

// camera channels sharing the frame store
`define SDV_CHANNELS      2

// pixel and memory word geometry
`define SDV_PIX_W         8
`define SDV_WORD_W        32
`define SDV_PIX_PER_WORD  4

// one frame is 16 words, i.e. 64 pixels
`define SDV_FRAME_WORDS   16
`define SDV_BURST_WORDS   4
`define SDV_FIFO_DEPTH    16

// channels x 2 banks x frame words
`define SDV_MEM_WORDS     64

// key must be stable this many cycles
`define SDV_KEY_HOLD      8

`endif

//--- hw/sdv_pkg.sv
`default_nettype none
`include "sdv_config.svh"

package sdv_pkg;

    typedef logic [$clog2(`SDV_CHANNELS)-1:0]    chan_t;
    typedef logic [$clog2(`SDV_FRAME_WORDS)-1:0] offset_t;

    // frame-store address, channel in the top bits
    typedef struct packed {
        chan_t   chan;
        logic    bank;
        offset_t offset;
    } mem_addr_t;

    // one memory word, seen whole or as its pixels (pixel 0 in low byte)
    typedef union packed {
        logic [`SDV_WORD_W-1:0]                       raw;
        logic [`SDV_PIX_PER_WORD-1:0][`SDV_PIX_W-1:0] pix;
    } pixel_word_u;

    typedef struct packed {
        logic                  frame_start;
        logic                  valid;
        logic [`SDV_PIX_W-1:0] data;
    } cam_pixel_t;

    typedef struct packed {
        logic        en;
        mem_addr_t   addr;
        pixel_word_u word;
    } wr_beat_t;

    typedef struct packed {
        logic wr_bank;
        logic rd_bank;
        logic rd_ready;
    } bank_state_t;

endpackage

`default_nettype wire

//--- hw/cam_write_channel.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module cam_write_channel (
    input  wire                  ddr_clk,
    input  wire                  arst_n,
    input  wire sdv_pkg::cam_pixel_t cam,
    input  wire                  grant,
    output logic                 req,
    output sdv_pkg::pixel_word_u head,
    output sdv_pkg::offset_t     offset,
    output logic                 frame_done
);
    import sdv_pkg::*;

    localparam int PTR_W = $clog2(`SDV_FIFO_DEPTH);
    localparam int SEL_W = $clog2(`SDV_PIX_PER_WORD);

    pixel_word_u      pack;
    pixel_word_u      next_word;
    logic [SEL_W-1:0] pix_cnt;
    logic             push;
    logic             push_ok;
    logic             pop;

    pixel_word_u      fifo_mem [`SDV_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // ----------------------------------------------------------------------
    // pixel packing
    // ----------------------------------------------------------------------
    always_comb begin
        next_word = pack;
        next_word.pix[pix_cnt] = cam.data;
    end

    // last pixel of a word goes straight into the FIFO
    assign push = cam.valid && !cam.frame_start &&
                  (pix_cnt == SEL_W'(`SDV_PIX_PER_WORD - 1));

    // full FIFO drops the word, the frame then never completes
    assign push_ok = push && ((count != (PTR_W+1)'(`SDV_FIFO_DEPTH)) || pop);

    // an empty FIFO never advances the offset
    assign pop = grant && (count != '0) && !frame_done && !cam.frame_start;

    always_ff @(posedge ddr_clk) begin
        if (cam.valid) begin
            pack <= next_word;
        end
        if (push_ok) begin
            fifo_mem[wr_ptr] <= next_word;
        end
    end

    // ----------------------------------------------------------------------
    // FIFO pointers and frame offset
    // ----------------------------------------------------------------------
    always_ff @(posedge ddr_clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_cnt    <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            offset     <= '0;
            frame_done <= 1'b0;
        end else if (cam.frame_start) begin
            pix_cnt    <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            offset     <= '0;
            frame_done <= 1'b0;
        end else begin
            if (cam.valid) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                offset <= offset + 1'b1;
                if (offset == offset_t'(`SDV_FRAME_WORDS - 1)) begin
                    frame_done <= 1'b1;
                end
            end
            count <= count + {{PTR_W{1'b0}}, push_ok} - {{PTR_W{1'b0}}, pop};
        end
    end

    assign head = fifo_mem[rd_ptr];
    assign req  = (count >= (PTR_W+1)'(`SDV_BURST_WORDS)) && !frame_done;

endmodule

`default_nettype wire

//--- hw/burst_arbiter.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module burst_arbiter (
    input  wire                       ddr_clk,
    input  wire                       arst_n,
    input  wire [`SDV_CHANNELS-1:0]   req,
    input  wire sdv_pkg::pixel_word_u head [`SDV_CHANNELS],
    input  wire sdv_pkg::offset_t     offset [`SDV_CHANNELS],
    input  wire [`SDV_CHANNELS-1:0]   wr_bank,
    output logic [`SDV_CHANNELS-1:0]  grant,
    output sdv_pkg::wr_beat_t         beat
);
    import sdv_pkg::*;

    localparam int CH     = `SDV_CHANNELS;
    localparam int BEAT_W = $clog2(`SDV_BURST_WORDS);

    // channel of the current or most recent window
    chan_t             last;
    chan_t             pick;
    chan_t             cand;
    logic              pick_valid;
    logic [BEAT_W-1:0] beat_cnt;

    // round robin, search starts one past the last served channel
    always_comb begin
        pick       = last;
        pick_valid = 1'b0;
        cand       = last;
        for (int i = 1; i <= CH; i++) begin
            cand = chan_t'((int'(last) + i) % CH);
            if (!pick_valid && req[cand]) begin
                pick       = cand;
                pick_valid = 1'b1;
            end
        end
    end

    // the zero-grant cycle between windows is where the next pick is made
    always_ff @(posedge ddr_clk or negedge arst_n) begin
        if (!arst_n) begin
            grant    <= '0;
            beat_cnt <= '0;
            last     <= '0;
        end else if (grant == '0) begin
            beat_cnt <= '0;
            if (pick_valid) begin
                grant <= {{(CH-1){1'b0}}, 1'b1} << pick;
                last  <= pick;
            end
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BEAT_W'(`SDV_BURST_WORDS - 1)) begin
                grant <= '0;
            end
        end
    end

    // write beat follows the granted channel's head word
    always_comb begin
        beat.en          = |grant;
        beat.addr.chan   = last;
        beat.addr.bank   = wr_bank[last];
        beat.addr.offset = offset[last];
        beat.word        = head[last];
    end

endmodule

`default_nettype wire

//--- hw/bank_switch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module bank_switch_ctrl (
    input  wire                      ddr_clk,
    input  wire                      arst_n,
    input  wire [`SDV_CHANNELS-1:0]  frame_start,
    input  wire [`SDV_CHANNELS-1:0]  frame_done,
    output sdv_pkg::bank_state_t     bank [`SDV_CHANNELS]
);

    // ping-pong per channel
    // a bank is published only once its frame landed in full,
    // otherwise the writer starts over in the same bank
    always_ff @(posedge ddr_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < `SDV_CHANNELS; n++) begin
                bank[n] <= '0;
            end
        end else begin
            for (int n = 0; n < `SDV_CHANNELS; n++) begin
                if (frame_start[n] && frame_done[n]) begin
                    bank[n].rd_bank  <= bank[n].wr_bank;
                    bank[n].rd_ready <= 1'b1;
                    bank[n].wr_bank  <= ~bank[n].wr_bank;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/frame_store.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module frame_store (
    input  wire                     ddr_clk,
    input  wire sdv_pkg::wr_beat_t  beat,
    input  wire sdv_pkg::mem_addr_t rd_addr,
    output sdv_pkg::pixel_word_u    rd_word
);

    logic [`SDV_WORD_W-1:0] mem [`SDV_MEM_WORDS];

    // one write port, read data one cycle after the address
    always_ff @(posedge ddr_clk) begin
        if (beat.en) begin
            mem[beat.addr] <= beat.word.raw;
        end
        rd_word.raw <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/key_channel_select.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module key_channel_select (
    input  wire             ddr_clk,
    input  wire             arst_n,
    input  wire             switch_key,
    output sdv_pkg::chan_t  read_channel
);
    import sdv_pkg::*;

    localparam int CNT_W = $clog2(`SDV_KEY_HOLD + 1);

    logic [1:0]       key_sync;
    logic [CNT_W-1:0] hold_cnt;

    // counter saturates while held, so one press gives one step
    always_ff @(posedge ddr_clk or negedge arst_n) begin
        if (!arst_n) begin
            key_sync     <= '0;
            hold_cnt     <= '0;
            read_channel <= '0;
        end else begin
            key_sync <= {key_sync[0], switch_key};
            if (!key_sync[1]) begin
                hold_cnt <= '0;
            end else if (hold_cnt != CNT_W'(`SDV_KEY_HOLD)) begin
                hold_cnt <= hold_cnt + 1'b1;
                if (hold_cnt == CNT_W'(`SDV_KEY_HOLD - 1)) begin
                    if (read_channel == chan_t'(`SDV_CHANNELS - 1)) begin
                        read_channel <= '0;
                    end else begin
                        read_channel <= read_channel + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/display_reader.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module display_reader (
    input  wire                       ddr_clk,
    input  wire                       arst_n,
    input  wire                       disp_frame_start,
    input  wire sdv_pkg::chan_t       read_channel,
    input  wire sdv_pkg::bank_state_t bank [`SDV_CHANNELS],
    output sdv_pkg::mem_addr_t        rd_addr,
    input  wire sdv_pkg::pixel_word_u rd_word,
    output logic                      pix_valid,
    output logic [`SDV_PIX_W-1:0]     pix_data
);
    import sdv_pkg::*;

    localparam int FRAME_PIX = `SDV_FRAME_WORDS * `SDV_PIX_PER_WORD;
    localparam int PCNT_W    = $clog2(FRAME_PIX);
    localparam int SEL_W     = $clog2(`SDV_PIX_PER_WORD);

    logic              start;
    logic              busy;
    logic [PCNT_W-1:0] pix_cnt;
    logic [SEL_W-1:0]  sel_d;
    chan_t             cur_chan;
    logic              cur_bank;

    // no readout from an unfinished bank, none over a running one
    assign start = disp_frame_start && !busy && !pix_valid &&
                   bank[read_channel].rd_ready;

    always_ff @(posedge ddr_clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            pix_cnt   <= '0;
            pix_valid <= 1'b0;
        end else begin
            // valid trails the address stage by the memory latency
            pix_valid <= busy;
            if (start) begin
                busy    <= 1'b1;
                pix_cnt <= '0;
            end else if (busy) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == PCNT_W'(FRAME_PIX - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ddr_clk) begin
        if (start) begin
            cur_chan <= read_channel;
            cur_bank <= bank[read_channel].rd_bank;
        end
        sel_d <= pix_cnt[SEL_W-1:0];
    end

    // address holds each word for all of its pixels
    always_comb begin
        rd_addr.chan   = cur_chan;
        rd_addr.bank   = cur_bank;
        rd_addr.offset = pix_cnt[PCNT_W-1:SEL_W];
    end

    assign pix_data = rd_word.pix[sel_d];

endmodule

`default_nettype wire

//--- hw/top_sdv.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module top_sdv (
    input  wire                                          ddr_clk,
    input  wire                                          arst_n,
    input  wire sdv_pkg::cam_pixel_t [`SDV_CHANNELS-1:0] cam,
    input  wire                                          switch_key,
    input  wire                                          disp_frame_start,
    output wire                                          pix_valid,
    output wire [`SDV_PIX_W-1:0]                         pix_data
);
    import sdv_pkg::*;

    wire [`SDV_CHANNELS-1:0] req;
    wire [`SDV_CHANNELS-1:0] grant;
    wire [`SDV_CHANNELS-1:0] frame_done;
    wire [`SDV_CHANNELS-1:0] frame_start;
    wire [`SDV_CHANNELS-1:0] wr_bank;
    wire pixel_word_u        head [`SDV_CHANNELS];
    wire offset_t            offset [`SDV_CHANNELS];
    wire bank_state_t        bank [`SDV_CHANNELS];
    wire wr_beat_t           beat;
    wire mem_addr_t          rd_addr;
    wire pixel_word_u        rd_word;
    wire chan_t              read_channel;

    // ----------------------------------------------------------------------
    // camera write channels
    // ----------------------------------------------------------------------
    for (genvar n = 0; n < `SDV_CHANNELS; n++) begin : g_chan
        assign frame_start[n] = cam[n].frame_start;
        assign wr_bank[n]     = bank[n].wr_bank;

        cam_write_channel cam_write_channel_inst (
            .ddr_clk    (ddr_clk),
            .arst_n     (arst_n),
            .cam        (cam[n]),
            .grant      (grant[n]),
            .req        (req[n]),
            .head       (head[n]),
            .offset     (offset[n]),
            .frame_done (frame_done[n])
        );
    end

    // ----------------------------------------------------------------------
    // write path into the frame store
    // ----------------------------------------------------------------------
    burst_arbiter burst_arbiter_inst (
        .ddr_clk (ddr_clk),
        .arst_n  (arst_n),
        .req     (req),
        .head    (head),
        .offset  (offset),
        .wr_bank (wr_bank),
        .grant   (grant),
        .beat    (beat)
    );

    bank_switch_ctrl bank_switch_ctrl_inst (
        .ddr_clk     (ddr_clk),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .bank        (bank)
    );

    frame_store frame_store_inst (
        .ddr_clk (ddr_clk),
        .beat    (beat),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    // ----------------------------------------------------------------------
    // display side
    // ----------------------------------------------------------------------
    key_channel_select key_channel_select_inst (
        .ddr_clk      (ddr_clk),
        .arst_n       (arst_n),
        .switch_key   (switch_key),
        .read_channel (read_channel)
    );

    display_reader display_reader_inst (
        .ddr_clk          (ddr_clk),
        .arst_n           (arst_n),
        .disp_frame_start (disp_frame_start),
        .read_channel     (read_channel),
        .bank             (bank),
        .rd_addr          (rd_addr),
        .rd_word          (rd_word),
        .pix_valid        (pix_valid),
        .pix_data         (pix_data)
    );

endmodule

`default_nettype wire

//--- dv/top_sdv_sva.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

module top_sdv_sva (
    input wire                     ddr_clk,
    input wire                     arst_n,
    input wire [`SDV_CHANNELS-1:0] grant,
    input wire                     beat_en,
    input wire sdv_pkg::chan_t     beat_chan,
    input wire                     pix_valid
);

    localparam int FRAME_PIX = `SDV_FRAME_WORDS * `SDV_PIX_PER_WORD;

    logic [7:0] grant_run;
    logic [7:0] valid_run;

    // length of the current run of high cycles
    always_ff @(posedge ddr_clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_run <= '0;
            valid_run <= '0;
        end else begin
            grant_run <= (|grant) ? grant_run + 8'd1 : 8'd0;
            valid_run <= pix_valid ? valid_run + 8'd1 : 8'd0;
        end
    end

    grant_onehot: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    grant_window: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        $fell(|grant) |-> (grant_run == 8'(`SDV_BURST_WORDS)))
        else $error("grant window length differs from the burst length");

    valid_window: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        $fell(pix_valid) |-> (valid_run == 8'(FRAME_PIX)))
        else $error("pix_valid run differs from one frame of pixels");

    // the addressed channel must be the granted one
    beat_granted: assert property (@(posedge ddr_clk) disable iff (!arst_n)
        beat_en |-> grant[beat_chan])
        else $error("write beat to a channel without its grant");

endmodule

`default_nettype wire

//--- dv/top_sdv_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "sdv_config.svh"

bind top_sdv top_sdv_sva top_sdv_sva_inst (
    .ddr_clk   (ddr_clk),
    .arst_n    (arst_n),
    .grant     (grant),
    .beat_en   (beat.en),
    .beat_chan (beat.addr.chan),
    .pix_valid (pix_valid)
);

module top_sdv_tb;
    import sdv_pkg::*;

    localparam int CH        = `SDV_CHANNELS;
    localparam int FRAME_PIX = `SDV_FRAME_WORDS * `SDV_PIX_PER_WORD;
    // (burst + idle) x channels x bursts per frame
    localparam int DRAIN     = 40;
    // five tests of at most 2000 cycles plus margin
    localparam int WATCHDOG_CYCLES = 5 * 2000 + 10000;

    logic                 ddr_clk;
    logic                 arst_n;
    cam_pixel_t [CH-1:0]  cam;
    logic                 switch_key;
    logic                 disp_frame_start;
    wire                  pix_valid;
    wire [`SDV_PIX_W-1:0] pix_data;

    integer               seed = 97;
    // reference model of the last published frame and the frame in progress
    logic [`SDV_PIX_W-1:0] shown   [CH][FRAME_PIX];
    logic [`SDV_PIX_W-1:0] pending [CH][FRAME_PIX];
    int                    pend_cnt [CH];

    top_sdv top_sdv_inst (
        .ddr_clk          (ddr_clk),
        .arst_n           (arst_n),
        .cam              (cam),
        .switch_key       (switch_key),
        .disp_frame_start (disp_frame_start),
        .pix_valid        (pix_valid),
        .pix_data         (pix_data)
    );

    initial begin
        ddr_clk = 1'b0;
        forever #10 ddr_clk = ~ddr_clk;
    end

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic stream_frame(input logic [CH-1:0] mask, input int npix);
        cam_pixel_t [CH-1:0] drive;
        logic [31:0]         r;
        for (int i = 0; i < npix; i++) begin
            @(posedge ddr_clk);
            drive = '0;
            for (int n = 0; n < CH; n++) begin
                if (mask[n]) begin
                    r                 = $random(seed);
                    pending[n][i]     = r[`SDV_PIX_W-1:0];
                    drive[n].valid    = 1'b1;
                    drive[n].data     = pending[n][i];
                end
            end
            cam <= drive;
        end
        @(posedge ddr_clk);
        cam <= '0;
        for (int n = 0; n < CH; n++) begin
            if (mask[n]) begin
                pend_cnt[n] = npix;
            end
        end
    endtask

    // frame_start after the drain bound publishes a full frame
    task automatic close_frame(input logic [CH-1:0] mask);
        cam_pixel_t [CH-1:0] drive;
        repeat (DRAIN) @(posedge ddr_clk);
        drive = '0;
        for (int n = 0; n < CH; n++) begin
            drive[n].frame_start = mask[n];
        end
        cam <= drive;
        @(posedge ddr_clk);
        cam <= '0;
        for (int n = 0; n < CH; n++) begin
            if (mask[n] && pend_cnt[n] == FRAME_PIX) begin
                for (int i = 0; i < FRAME_PIX; i++) begin
                    shown[n][i] = pending[n][i];
                end
            end
            if (mask[n]) begin
                pend_cnt[n] = 0;
            end
        end
    endtask

    task automatic pulse_display_start();
        @(posedge ddr_clk);
        disp_frame_start <= 1'b1;
        @(posedge ddr_clk);
        disp_frame_start <= 1'b0;
    endtask

    task automatic press_key(input int hold);
        @(posedge ddr_clk);
        switch_key <= 1'b1;
        repeat (hold) @(posedge ddr_clk);
        switch_key <= 1'b0;
        repeat (4) @(posedge ddr_clk);
    endtask

    // pix_valid two cycles after the pulse and then one frame in order
    task automatic display_and_compare(input int chan);
        int waited;
        pulse_display_start();
        waited = 0;
        @(negedge ddr_clk);
        while (!pix_valid) begin
            waited++;
            if (waited > 8) begin
                abort_run("pix_valid never rose after a display start");
            end
            @(negedge ddr_clk);
        end
        check_value("pix_valid latency", waited, 1);
        for (int i = 0; i < FRAME_PIX; i++) begin
            check_value("pix_valid", pix_valid, 1);
            check_value($sformatf("pix_data[%0d]", i), pix_data, shown[chan][i]);
            @(negedge ddr_clk);
        end
        check_value("pix_valid", pix_valid, 0);
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_idle_after_reset();
        pulse_display_start();
        repeat (80) begin
            @(negedge ddr_clk);
            check_value("pix_valid", pix_valid, 0);
        end
    endtask

    task automatic test_single_frame();
        stream_frame(2'b01, FRAME_PIX);
        close_frame(2'b01);
        display_and_compare(0);
    endtask

    task automatic test_key_switch();
        stream_frame(2'b11, FRAME_PIX);
        close_frame(2'b11);
        display_and_compare(0);
        press_key(12);
        display_and_compare(1);
    endtask

    task automatic test_partial_frame();
        stream_frame(2'b10, 30);
        close_frame(2'b10);
        display_and_compare(1);
    endtask

    task automatic test_bank_toggle();
        stream_frame(2'b10, FRAME_PIX);
        close_frame(2'b10);
        stream_frame(2'b10, FRAME_PIX);
        // second frame lands in the other bank, first one still shown
        repeat (DRAIN) @(posedge ddr_clk);
        display_and_compare(1);
        close_frame(2'b10);
        display_and_compare(1);
    endtask

    initial begin
        arst_n           = 1'b0;
        cam              = '0;
        switch_key       = 1'b0;
        disp_frame_start = 1'b0;
        for (int n = 0; n < CH; n++) begin
            pend_cnt[n] = 0;
        end
        repeat (8) @(posedge ddr_clk);
        arst_n <= 1'b1;

        test_idle_after_reset();
        repeat (DRAIN) @(posedge ddr_clk);
        test_single_frame();
        repeat (DRAIN) @(posedge ddr_clk);
        test_key_switch();
        repeat (DRAIN) @(posedge ddr_clk);
        test_partial_frame();
        repeat (DRAIN) @(posedge ddr_clk);
        test_bank_toggle();
        repeat (DRAIN) @(posedge ddr_clk);

        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ddr_clk);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/sdv_pkg.sv
hw/cam_write_channel.sv
hw/burst_arbiter.sv
hw/bank_switch_ctrl.sv
hw/frame_store.sv
hw/key_channel_select.sv
hw/display_reader.sv
hw/top_sdv.sv
dv/top_sdv_sva.sv
dv/top_sdv_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module top_sdv_tb -o sim_top_sdv
	./obj_dir/sim_top_sdv

clean:
	rm -rf obj_dir
